// ==== filelist.f ====
+incdir+verification
source/aipPkg.sv
source/aipRam.sv
source/aipConfigBank.sv
source/aipStatus.sv
source/aipHostCtrl.sv
source/aipTop.sv
verification/aipTb.sv

// ==== Bender.yml ====
package:
  name: aip

sources:
  - files:
      - source/aipPkg.sv
      - source/aipRam.sv
      - source/aipConfigBank.sv
      - source/aipStatus.sv
      - source/aipHostCtrl.sv
      - source/aipTop.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/aipTb.sv

// ==== verification/aipTbTasks.svh ====
`ifndef AIP_TB_TASKS_SVH
`define AIP_TB_TASKS_SVH

task automatic compareValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
  if (actual !== expected) begin
    $display("Error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
    failCount++;
  end else begin
    passCount++;
  end
endtask

task automatic reportTest(input string name, input int failsBefore);
  if (failCount == failsBefore) begin
    $display("Test %s: passed", name);
  end else begin
    $display("Test %s: failed with %0d errors", name, failCount - failsBefore);
  end
endtask

// Read view layout: mask, pending, busy in bit 0
function automatic logic [31:0] expectedStatus(input logic busy, input logic [7:0] pending,
                                               input logic [7:0] mask);
  return {8'h00, mask, pending, 7'h00, busy};
endfunction

task automatic hostWrite(input logic [4:0] code, input logic [31:0] data);
  @(negedge clk);
  cfgCode = code;
  dataIn  = data;
  writeIn = 1'b1;
  @(negedge clk);
  writeIn = 1'b0;
endtask

// Samples before the edge that acts on the strobe
task automatic hostRead(input logic [4:0] code, input logic strobe, output logic [31:0] word);
  @(negedge clk);
  cfgCode = code;
  readIn  = strobe;
  #SettleDelay;
  word = dataOut;
  @(negedge clk);
  readIn = 1'b0;
endtask

task automatic coreWriteOut(input logic [3:0] addr, input logic [31:0] data);
  @(negedge clk);
  coreReq.wrEnMemOut   = 1'b1;
  coreReq.wrAddrMemOut = 16'(addr);
  coreReq.wrDataMemOut = data;
  @(negedge clk);
  coreReq.wrEnMemOut = 1'b0;
endtask

task automatic checkResetState();
  int          failsBefore;
  logic [31:0] word;
  failsBefore = failCount;
  hostRead(5'd31, 1'b0, word);
  compareValue("dataOutAIP_o", 32'h1000_500A, word);
  hostRead(5'd30, 1'b0, word);
  compareValue("dataOutAIP_o", 32'h0, word);
  for (int code = 8; code < 30; code++) begin
    hostRead(5'(code), 1'b0, word);  // Unused codes
    compareValue("dataOutAIP_o", 32'h0, word);
  end
  compareValue("intAIP_o", 32'h0, intOut);
  reportTest("reset values", failsBefore);
endtask

task automatic fillInputMemories();
  int          failsBefore;
  logic [31:0] words0 [8];
  logic [31:0] words1 [8];
  logic [2:0]  addr;
  logic [2:0]  addr1;
  failsBefore = failCount;
  hostWrite(CfgMemIn0Addr, 32'd5);
  for (int i = 0; i < 5; i++) begin
    addr = 3'((5 + i) % 8);  // Pointer wraps at depth 8
    words0[addr] = $random(seed);
    hostWrite(CfgMemIn0Data, words0[addr]);
  end
  hostWrite(CfgMemIn1Addr, 32'd5);
  for (int i = 0; i < 5; i++) begin
    addr = 3'((5 + i) % 8);
    words1[addr] = $random(seed);
    hostWrite(CfgMemIn1Data, words1[addr]);
  end
  for (int i = 0; i < 5; i++) begin
    addr  = 3'((5 + i) % 8);
    addr1 = 3'((9 - i) % 8);  // Opposite order, so the two read ports differ
    @(negedge clk);
    coreReq.rdAddrMemIn0 = 16'(addr);
    coreReq.rdAddrMemIn1 = 16'(addr1);
    #SettleDelay;
    compareValue("coreResp_o.rdDataMemIn0", words0[addr], coreResp.rdDataMemIn0);
    compareValue("coreResp_o.rdDataMemIn1", words1[addr1], coreResp.rdDataMemIn1);
  end
  reportTest("input memories", failsBefore);
endtask

task automatic drainOutputMemory();
  int          failsBefore;
  logic [31:0] word;
  failsBefore = failCount;
  for (int a = 0; a < 16; a++) begin
    outWords[a] = $random(seed);
    coreWriteOut(4'(a), outWords[a]);
  end
  hostWrite(CfgMemOutAddr, 32'd14);
  for (int k = 0; k < 4; k++) begin
    hostRead(CfgMemOutData, 1'b1, word);
    compareValue("dataOutAIP_o", outWords[(14 + k) % 16], word);
  end
  reportTest("output memory", failsBefore);
endtask

task automatic writeConfigReg();
  int          failsBefore;
  logic [31:0] word;
  failsBefore = failCount;
  word = $random(seed);
  hostWrite(CfgConfData, word);
  compareValue("coreResp_o.confReg", word, coreResp.confReg);
  word = $random(seed);
  hostWrite(CfgConfData, word);  // Single register, so this overwrites
  compareValue("coreResp_o.confReg", word, coreResp.confReg);
  @(negedge clk);
  startIn = 1'b1;
  #SettleDelay;
  compareValue("coreResp_o.start", 32'h1, coreResp.start);
  @(negedge clk);
  startIn = 1'b0;
  #SettleDelay;
  compareValue("coreResp_o.start", 32'h0, coreResp.start);
  reportTest("config register", failsBefore);
endtask

task automatic exerciseStatusIrq();
  int          failsBefore;
  logic [31:0] word;
  failsBefore = failCount;
  @(negedge clk);
  coreReq.busy = 1'b1;
  hostRead(CfgStatus, 1'b0, word);
  compareValue("dataOutAIP_o", expectedStatus(1'b1, 8'h00, 8'h00), word);
  @(negedge clk);
  coreReq.done = 1'b1;
  @(negedge clk);
  coreReq.done = 1'b0;
  hostRead(CfgStatus, 1'b0, word);
  compareValue("dataOutAIP_o", expectedStatus(1'b1, 8'h02, 8'h00), word);
  compareValue("intAIP_o", 32'h0, intOut);
  hostWrite(CfgStatus, 32'h0002_0000);  // Unmask flag 1
  compareValue("intAIP_o", 32'h1, intOut);
  hostWrite(CfgStatus, 32'h0002_0200);  // Clear flag 1, keep the mask
  compareValue("intAIP_o", 32'h0, intOut);
  hostRead(CfgStatus, 1'b0, word);
  compareValue("dataOutAIP_o", expectedStatus(1'b1, 8'h00, 8'h02), word);
  coreReq.busy = 1'b0;
  reportTest("status and interrupt", failsBefore);
endtask

task automatic holdPointerWhileDisabled();
  int          failsBefore;
  logic [31:0] word;
  failsBefore = failCount;
  hostWrite(CfgMemOutAddr, 32'd3);
  @(negedge clk);
  enIn = 1'b0;
  hostWrite(CfgMemOutAddr, 32'd9);
  hostRead(CfgMemOutData, 1'b1, word);
  compareValue("dataOutAIP_o", outWords[3], word);
  @(negedge clk);
  enIn = 1'b1;
  hostRead(CfgMemOutData, 1'b0, word);  // Same word again
  compareValue("dataOutAIP_o", outWords[3], word);
  reportTest("enable gating", failsBefore);
endtask

`endif

// ==== verification/aipTb.sv ====
`default_nettype none

module aipTb;
  import aipPkg::*;

  localparam int HalfPeriod    = 50;
  localparam int SettleDelay   = 20;    // Sample point in the low clock phase
  localparam int TimeoutCycles = 2000;  // Roughly ten times the full test sequence

  logic                   clk;
  logic                   rst;
  logic                   enIn;
  logic [ConfigWidth-1:0] cfgCode;
  logic [DataWidth-1:0]   dataIn;
  logic                   readIn;
  logic                   writeIn;
  logic                   startIn;
  coreReq_t               coreReq;
  logic [DataWidth-1:0]   dataOut;
  logic                   intOut;
  coreResp_t              coreResp;

  integer               seed = 32'hf580_4ca8;
  int                   passCount = 0;
  int                   failCount = 0;
  int                   cycleCount = 0;
  logic [DataWidth-1:0] outWords [16];  // Output memory image, reused by the enable test

  aipTop aipTop_inst (
    .clk         (clk),
    .rst         (rst),
    .en_i        (enIn),
    .configAIP_i (cfgCode),
    .dataInAIP_i (dataIn),
    .readAIP_i   (readIn),
    .writeAIP_i  (writeIn),
    .startAIP_i  (startIn),
    .coreReq_i   (coreReq),
    .dataOutAIP_o(dataOut),
    .intAIP_o    (intOut),
    .coreResp_o  (coreResp)
  );

  `include "aipTbTasks.svh"

  initial clk = 1'b0;
  always #HalfPeriod clk = ~clk;

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= TimeoutCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    rst     = 1'b0;
    enIn    = 1'b1;
    cfgCode = '0;
    dataIn  = '0;
    readIn  = 1'b0;
    writeIn = 1'b0;
    startIn = 1'b0;
    coreReq = '0;
    repeat (3) @(negedge clk);
    rst = 1'b1;

    checkResetState();
    fillInputMemories();
    drainOutputMemory();
    writeConfigReg();
    exerciseStatusIrq();
    holdPointerWhileDisabled();

    @(negedge clk);
    $display("Checks passed: %0d, checks failed: %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/aipTop.sv ====
`default_nettype none

module aipTop #(
  parameter int MemInAddrWidth  = 3,
  parameter int MemOutAddrWidth = 4,
  parameter int ConfRegs        = 1
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           en_i,
  input  logic [aipPkg::ConfigWidth-1:0] configAIP_i,
  input  logic [aipPkg::DataWidth-1:0]   dataInAIP_i,
  input  logic                           readAIP_i,
  input  logic                           writeAIP_i,
  input  logic                           startAIP_i,
  input  aipPkg::coreReq_t               coreReq_i,
  output logic [aipPkg::DataWidth-1:0]   dataOutAIP_o,
  output logic                           intAIP_o,
  output aipPkg::coreResp_t              coreResp_o
);
  import aipPkg::*;

  logic [1:0]                            memInWrEn;
  logic [MemInAddrWidth-1:0]             memInWrAddr0;
  logic [MemInAddrWidth-1:0]             memInWrAddr1;
  logic [MemOutAddrWidth-1:0]            memOutRdAddr;
  logic [DataWidth-1:0]                  memOutRdData;
  logic                                  confWrEn;
  logic                                  confAddrLoad;
  logic                                  statusWrite;
  statusWord_u                           statusView;
  logic [ConfRegs-1:0][DataWidth-1:0]    confWords;

  aipHostCtrl #(
    .MemInAddrWidth (MemInAddrWidth),
    .MemOutAddrWidth(MemOutAddrWidth)
  ) ctrl (
    .clk           (clk),
    .rst           (rst),
    .en_i          (en_i),
    .configAIP_i   (configAIP_i),
    .dataInAIP_i   (dataInAIP_i),
    .readAIP_i     (readAIP_i),
    .writeAIP_i    (writeAIP_i),
    .memOutData_i  (memOutRdData),
    .statusView_i  (statusView),
    .memInWrEn_o   (memInWrEn),
    .memInWrAddr0_o(memInWrAddr0),
    .memInWrAddr1_o(memInWrAddr1),
    .memOutRdAddr_o(memOutRdAddr),
    .confWrEn_o    (confWrEn),
    .confAddrLoad_o(confAddrLoad),
    .statusWrite_o (statusWrite),
    .dataOutAIP_o  (dataOutAIP_o)
  );

  // Host fills the input memories, core reads them
  aipRam #(.AddrWidth(MemInAddrWidth)) memIn0 (
    .clk     (clk),
    .wrEn_i  (memInWrEn[0]),
    .wrAddr_i(memInWrAddr0),
    .wrData_i(dataInAIP_i),
    .rdAddr_i(coreReq_i.rdAddrMemIn0[MemInAddrWidth-1:0]),
    .rdData_o(coreResp_o.rdDataMemIn0)
  );

  aipRam #(.AddrWidth(MemInAddrWidth)) memIn1 (
    .clk     (clk),
    .wrEn_i  (memInWrEn[1]),
    .wrAddr_i(memInWrAddr1),
    .wrData_i(dataInAIP_i),
    .rdAddr_i(coreReq_i.rdAddrMemIn1[MemInAddrWidth-1:0]),
    .rdData_o(coreResp_o.rdDataMemIn1)
  );

  // Core fills, host drains
  aipRam #(.AddrWidth(MemOutAddrWidth)) memOut (
    .clk     (clk),
    .wrEn_i  (coreReq_i.wrEnMemOut),
    .wrAddr_i(coreReq_i.wrAddrMemOut[MemOutAddrWidth-1:0]),
    .wrData_i(coreReq_i.wrDataMemOut),
    .rdAddr_i(memOutRdAddr),
    .rdData_o(memOutRdData)
  );

  aipConfigBank #(.ConfRegs(ConfRegs)) confBank (
    .clk        (clk),
    .rst        (rst),
    .en_i       (en_i),
    .addrLoad_i (confAddrLoad),
    .wrEn_i     (confWrEn),
    .data_i     (dataInAIP_i),
    .conf_o     (confWords)
  );

  aipStatus status (
    .clk       (clk),
    .rst       (rst),
    .write_i   (statusWrite),
    .data_i    (dataInAIP_i),
    .coreBusy_i(coreReq_i.busy),
    .coreDone_i(coreReq_i.done),
    .view_o    (statusView),
    .int_o     (intAIP_o)
  );

  assign coreResp_o.confReg = confWords[0];
  assign coreResp_o.start   = startAIP_i;  // Straight from the host strobe

endmodule

`default_nettype wire

// ==== source/aipHostCtrl.sv ====
`default_nettype none

module aipHostCtrl #(
  parameter int MemInAddrWidth  = 3,
  parameter int MemOutAddrWidth = 4
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           en_i,
  input  logic [aipPkg::ConfigWidth-1:0] configAIP_i,
  input  logic [aipPkg::DataWidth-1:0]   dataInAIP_i,
  input  logic                           readAIP_i,
  input  logic                           writeAIP_i,
  input  logic [aipPkg::DataWidth-1:0]   memOutData_i,
  input  aipPkg::statusWord_u            statusView_i,
  output logic [1:0]                     memInWrEn_o,
  output logic [MemInAddrWidth-1:0]      memInWrAddr0_o,
  output logic [MemInAddrWidth-1:0]      memInWrAddr1_o,
  output logic [MemOutAddrWidth-1:0]     memOutRdAddr_o,
  output logic                           confWrEn_o,
  output logic                           confAddrLoad_o,
  output logic                           statusWrite_o,
  output logic [aipPkg::DataWidth-1:0]   dataOutAIP_o
);
  import aipPkg::*;

  logic [MemAddrMax-1:0]      hostAddr;
  logic                       in0Write;
  logic                       in0Load;
  logic                       in1Write;
  logic                       in1Load;
  logic                       outRead;
  logic                       outLoad;
  logic [MemInAddrWidth-1:0]  wrPtr0;
  logic [MemInAddrWidth-1:0]  wrPtr1;
  logic [MemOutAddrWidth-1:0] rdPtrOut;

  assign hostAddr = dataInAIP_i[MemAddrMax-1:0];

  // Config code decode
  assign in0Write = writeAIP_i && (configAIP_i == CfgMemIn0Data);
  assign in0Load  = writeAIP_i && (configAIP_i == CfgMemIn0Addr);
  assign in1Write = writeAIP_i && (configAIP_i == CfgMemIn1Data);
  assign in1Load  = writeAIP_i && (configAIP_i == CfgMemIn1Addr);
  assign outRead  = readAIP_i  && (configAIP_i == CfgMemOutData);
  assign outLoad  = writeAIP_i && (configAIP_i == CfgMemOutAddr);

  assign memInWrEn_o    = {in1Write, in0Write};
  assign confWrEn_o     = writeAIP_i && (configAIP_i == CfgConfData);
  assign confAddrLoad_o = writeAIP_i && (configAIP_i == CfgConfAddr);
  assign statusWrite_o  = writeAIP_i && (configAIP_i == CfgStatus);

  // Pointers wrap naturally at the memory depth
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wrPtr0   <= '0;
      wrPtr1   <= '0;
      rdPtrOut <= '0;
    end else if (en_i) begin
      if (in0Load) begin
        wrPtr0 <= hostAddr[MemInAddrWidth-1:0];
      end else if (in0Write) begin
        wrPtr0 <= wrPtr0 + 1'b1;
      end

      if (in1Load) begin
        wrPtr1 <= hostAddr[MemInAddrWidth-1:0];
      end else if (in1Write) begin
        wrPtr1 <= wrPtr1 + 1'b1;
      end

      if (outLoad) begin
        rdPtrOut <= hostAddr[MemOutAddrWidth-1:0];
      end else if (outRead) begin
        rdPtrOut <= rdPtrOut + 1'b1;  // Next word shows next cycle
      end
    end
  end

  assign memInWrAddr0_o = wrPtr0;
  assign memInWrAddr1_o = wrPtr1;
  assign memOutRdAddr_o = rdPtrOut;

  // Host read mux, zero latency
  always_comb begin
    case (configAIP_i)
      CfgMemOutData: dataOutAIP_o = memOutData_i;
      CfgStatus:     dataOutAIP_o = statusView_i;
      CfgId:         dataOutAIP_o = IpId;
      default:       dataOutAIP_o = '0;
    endcase
  end

  // Memories, config bank and status unit never see two writes at once
  assert property (@(posedge clk) disable iff (!rst)
    $onehot0({memInWrEn_o, confWrEn_o, statusWrite_o}))
    else $error("More than one write enable active");

endmodule

`default_nettype wire

// ==== source/aipStatus.sv ====
`default_nettype none

module aipStatus (
  input  logic                clk,
  input  logic                rst,
  input  logic                write_i,
  input  aipPkg::statusWord_u data_i,
  input  logic                coreBusy_i,
  input  logic                coreDone_i,
  output aipPkg::statusWord_u view_o,
  output logic                int_o
);
  import aipPkg::*;

  logic [StatusWidth-1:0] pending;
  logic [StatusWidth-1:0] mask;
  logic [StatusWidth-1:0] clearFlags;
  logic [StatusWidth-1:0] setFlags;

  assign clearFlags = write_i ? data_i.wr.clearPending : '0;
  assign setFlags   = {{(StatusWidth-2){1'b0}}, coreDone_i, 1'b0};  // Done is flag 1

  // Set wins over a clear at the same edge
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~clearFlags) | setFlags;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      mask <= '0;
    end else if (write_i) begin
      mask <= data_i.wr.newMask;
    end
  end

  assign int_o = |(pending & mask);

  always_comb begin
    view_o               = '0;
    view_o.rd.coreStatus = {{(StatusWidth-1){1'b0}}, coreBusy_i};
    view_o.rd.pending    = pending;
    view_o.rd.mask       = mask;
  end

  assert property (@(posedge clk) disable iff (!rst)
    int_o |-> (view_o.rd.pending != '0))
    else $error("Interrupt without pending flag");

endmodule

`default_nettype wire

// ==== source/aipConfigBank.sv ====
`default_nettype none

module aipConfigBank #(
  parameter int ConfRegs = 1
) (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       en_i,
  input  logic                                       addrLoad_i,
  input  logic                                       wrEn_i,
  input  logic [aipPkg::DataWidth-1:0]               data_i,
  output logic [ConfRegs-1:0][aipPkg::DataWidth-1:0] conf_o
);
  import aipPkg::*;

  localparam int PtrWidth = (ConfRegs > 1) ? $clog2(ConfRegs) : 1;

  logic [PtrWidth-1:0] wrPtr;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wrPtr <= '0;
    end else if (en_i) begin
      if (addrLoad_i) begin
        // Out of range loads fall back to register 0
        wrPtr <= (data_i[PtrWidth-1:0] < ConfRegs) ? data_i[PtrWidth-1:0] : '0;
      end else if (wrEn_i) begin
        wrPtr <= (wrPtr == PtrWidth'(ConfRegs - 1)) ? '0 : wrPtr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      conf_o <= '0;
    end else if (wrEn_i) begin
      conf_o[wrPtr] <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== source/aipRam.sv ====
`default_nettype none

module aipRam #(
  parameter int AddrWidth = 3
) (
  input  logic                         clk,
  input  logic                         wrEn_i,
  input  logic [AddrWidth-1:0]         wrAddr_i,
  input  logic [aipPkg::DataWidth-1:0] wrData_i,
  input  logic [AddrWidth-1:0]         rdAddr_i,
  output logic [aipPkg::DataWidth-1:0] rdData_o
);
  import aipPkg::*;

  logic [DataWidth-1:0] mem [2**AddrWidth];

  always_ff @(posedge clk) begin
    if (wrEn_i) begin
      mem[wrAddr_i] <= wrData_i;
    end
  end

  assign rdData_o = mem[rdAddr_i];  // Asynchronous read

  assert property (@(posedge clk) wrEn_i |-> !$isunknown(wrAddr_i))
    else $error("Write with unknown address");

endmodule

`default_nettype wire

// ==== source/aipPkg.sv ====
`default_nettype none

package aipPkg;

  localparam int DataWidth   = 32;
  localparam int ConfigWidth = 5;
  localparam int StatusWidth = 8;
  localparam int MemAddrMax  = 16;

  localparam logic [DataWidth-1:0] IpId = 32'h1000500A;

  // Host config codes, data code even and address code odd
  localparam logic [ConfigWidth-1:0] CfgMemIn0Data = 5'd0;
  localparam logic [ConfigWidth-1:0] CfgMemIn0Addr = 5'd1;
  localparam logic [ConfigWidth-1:0] CfgMemIn1Data = 5'd2;
  localparam logic [ConfigWidth-1:0] CfgMemIn1Addr = 5'd3;
  localparam logic [ConfigWidth-1:0] CfgMemOutData = 5'd4;
  localparam logic [ConfigWidth-1:0] CfgMemOutAddr = 5'd5;
  localparam logic [ConfigWidth-1:0] CfgConfData   = 5'd6;
  localparam logic [ConfigWidth-1:0] CfgConfAddr   = 5'd7;
  localparam logic [ConfigWidth-1:0] CfgStatus     = 5'd30;
  localparam logic [ConfigWidth-1:0] CfgId         = 5'd31;

  typedef struct packed {
    logic [MemAddrMax-1:0] rdAddrMemIn0;
    logic [MemAddrMax-1:0] rdAddrMemIn1;
    logic [DataWidth-1:0]  wrDataMemOut;
    logic [MemAddrMax-1:0] wrAddrMemOut;
    logic                  wrEnMemOut;
    logic                  busy;
    logic                  done;      // One clock pulse
    logic [4:0]            padding;
  } coreReq_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdDataMemIn0;
    logic [DataWidth-1:0] rdDataMemIn1;
    logic [DataWidth-1:0] confReg;
    logic                 start;
  } coreResp_t;

  typedef struct packed {
    logic [DataWidth-3*StatusWidth-1:0] zero;
    logic [StatusWidth-1:0]             mask;
    logic [StatusWidth-1:0]             pending;
    logic [StatusWidth-1:0]             coreStatus;  // Bit 0 is busy
  } statusRd_t;

  typedef struct packed {
    logic [DataWidth-3*StatusWidth-1:0] unusedHi;
    logic [StatusWidth-1:0]             newMask;
    logic [StatusWidth-1:0]             clearPending;  // 1 clears that flag
    logic [StatusWidth-1:0]             unusedLo;
  } statusWr_t;

  // Same status word, decoded differently for host reads and writes
  typedef union packed {
    statusRd_t rd;
    statusWr_t wr;
  } statusWord_u;

endpackage

`default_nettype wire
